// File: list.f
ntm_sinh_pkg.sv
ntm_scalar_modular_multiplier.sv
ntm_scalar_integer_divider.sv
ntm_scalar_sinh_function.sv
ntm_vector_sinh_function.sv
ntm_sinh_tb_clock.sv
ntm_sinh_tb.sv

// File: Makefile
# Verilator build and run for the sinh vector subsystem

VERILATOR ?= verilator
TOP       ?= ntm_sinh_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

# Every source named in the file list
SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^test passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ntm_sinh_tb.sv
//////////////////////////////
// Sinh vector testbench
// Table of vectors checked against a series model
// Fixed edge rows plus seeded random rows
//////////////////////////////

module ntm_sinh_tb import ntm_sinh_pkg::*; ();

  localparam int MAX_ELEMS = 8;
  localparam int NUM_FIXED = 5;
  localparam int NUM_ROWS  = 12;

  // One vector with element 0 in the low slot
  typedef struct packed {
    logic [DATA_SIZE-1:0]                modulo;
    logic [DATA_SIZE-1:0]                size;
    logic [MAX_ELEMS-1:0][DATA_SIZE-1:0] data;
    logic [MAX_ELEMS-1:0][3:0]           idle;
    logic [MAX_ELEMS-1:0][DATA_SIZE-1:0] expected;
  } vector_row_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic                 data_in_enable;
  logic [DATA_SIZE-1:0] size_in;
  sinh_operand_t        operand_in;
  logic                 ready;
  logic                 data_out_enable;
  logic [DATA_SIZE-1:0] data_out;

  vector_row_t table_rows [NUM_ROWS];

  // Run bookkeeping
  integer seed         = 68;
  int     limit_cycles = 0;
  int     row_index    = 0;
  int     elem_index   = 0;
  int     total_pulses = 0;

  ntm_sinh_tb_clock clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_vector_sinh_function ntm_vector_sinh_function_i (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .DATA_IN_ENABLE  (data_in_enable),
    .SIZE_IN         (size_in),
    .OPERAND_IN      (operand_in),
    .READY           (ready),
    .DATA_OUT_ENABLE (data_out_enable),
    .DATA_OUT        (data_out)
  );

  //////////////////////////////
  // Model and checks
  //////////////////////////////

  // Series x + x^3/3! + x^5/5! + x^7/7! with each step floored and the sum taken mod m
  function automatic logic [DATA_SIZE-1:0] sinh_reference(
    input logic [DATA_SIZE-1:0] modulo,
    input logic [DATA_SIZE-1:0] data
  );
    longint unsigned m;
    longint unsigned x;
    longint unsigned term;
    longint unsigned sum;
    longint unsigned denom;
    m    = {48'd0, modulo};
    x    = {48'd0, data} % m;
    sum  = x;
    term = x;
    for (int k = 1; k <= 3; k++) begin
      denom = 64'((2 * k) * (2 * k + 1));
      term  = (((term * x) % m) * x) % m;
      term  = term / denom;
      sum   = (sum + term) % m;
    end
    return sum[DATA_SIZE-1:0];
  endfunction

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_data(
    input string                name,
    input logic [DATA_SIZE-1:0] actual,
    input logic [DATA_SIZE-1:0] expected
  );
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h (row %0d, element %0d)",
               name, actual, expected, row_index, elem_index);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h (row %0d, element %0d)",
               name, actual, expected, row_index, elem_index);
      stop_run();
    end
  endtask

  // Quiet outputs from reset until the first START
  task automatic check_reset_outputs();
    check_flag("READY", ready, 1'b0);
    check_flag("DATA_OUT_ENABLE", data_out_enable, 1'b0);
    check_data("DATA_OUT", data_out, '0);
  endtask

  //////////////////////////////
  // Table
  //////////////////////////////

  task automatic build_table();
    int shift;
    int total;
    // Single element
    table_rows[0]        = '0;
    table_rows[0].modulo = 16'd1000;
    table_rows[0].size   = 16'd1;
    table_rows[0].data   = {16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd5};
    // Several elements with a prime modulus and some idle gaps
    table_rows[1]        = '0;
    table_rows[1].modulo = 16'd65521;
    table_rows[1].size   = 16'd5;
    table_rows[1].data   = {16'd0, 16'd0, 16'd0, 16'd12345, 16'd100, 16'd3, 16'd2, 16'd1};
    table_rows[1].idle   = {4'd0, 4'd0, 4'd0, 4'd3, 4'd0, 4'd7, 4'd1, 4'd2};
    // Zero, equal to m, above m
    table_rows[2]        = '0;
    table_rows[2].modulo = 16'd97;
    table_rows[2].size   = 16'd4;
    table_rows[2].data   = {16'd0, 16'd0, 16'd0, 16'd0, 16'd65535, 16'd500, 16'd97, 16'd0};
    // Modulus of one
    table_rows[3]        = '0;
    table_rows[3].modulo = 16'd1;
    table_rows[3].size   = 16'd2;
    table_rows[3].data   = {16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd1234, 16'd0};
    // Largest modulus with long gaps
    table_rows[4]        = '0;
    table_rows[4].modulo = 16'd65535;
    table_rows[4].size   = 16'd3;
    table_rows[4].data   = {16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd7, 16'd40000, 16'd65534};
    table_rows[4].idle   = {4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd15, 4'd12, 4'd9};
    // Random rows with moduli spread over many magnitudes
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
      table_rows[r] = '0;
      shift = int'($unsigned($random(seed)) % 12);
      table_rows[r].modulo = 16'($random(seed)) >> shift;
      if (table_rows[r].modulo == '0) begin
        table_rows[r].modulo = 16'd1;
      end
      table_rows[r].size = 16'($unsigned($random(seed)) % 8 + 1);
      for (int e = 0; e < MAX_ELEMS; e++) begin
        table_rows[r].data[e] = 16'($random(seed));
        table_rows[r].idle[e] = 4'($random(seed));
      end
    end
    // Expected results and run length
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += int'(table_rows[r].size);
      for (int e = 0; e < MAX_ELEMS; e++) begin
        table_rows[r].expected[e] = sinh_reference(table_rows[r].modulo, table_rows[r].data[e]);
      end
    end
    // Per element budget of twelve bit-serial runs plus the idle gap
    limit_cycles = total * (12 * (DATA_SIZE + 2) + 16) + 64 * NUM_ROWS + 100;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Idle gap with no output before one strobe
  task automatic apply_element(
    input logic [DATA_SIZE-1:0] modulo,
    input logic [DATA_SIZE-1:0] data,
    input logic [3:0]           idle
  );
    repeat (idle) begin
      @(negedge CLK);
      check_flag("DATA_OUT_ENABLE", data_out_enable, 1'b0);
      check_flag("READY", ready, 1'b0);
    end
    operand_in.modulo = modulo;
    operand_in.data   = data;
    data_in_enable    = 1'b1;
    @(negedge CLK);
    data_in_enable = 1'b0;
    operand_in     = '1;
  endtask

  task automatic wait_result(input logic [DATA_SIZE-1:0] expected, input logic last);
    while (data_out_enable !== 1'b1) begin
      check_flag("READY", ready, 1'b0);
      @(negedge CLK);
    end
    check_data("DATA_OUT", data_out, expected);
    check_flag("READY", ready, last);
  endtask

  task automatic run_row(input int row);
    vector_row_t r;
    int          base;
    r         = table_rows[row];
    row_index = row;
    base      = total_pulses;
    size_in   = r.size;
    start     = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    for (int e = 0; e < int'(r.size); e++) begin
      elem_index = e;
      apply_element(r.modulo, r.data[e], r.idle[e]);
      wait_result(r.expected[e], e == int'(r.size) - 1);
    end
    // Nothing trails the last result
    @(negedge CLK);
    check_flag("DATA_OUT_ENABLE", data_out_enable, 1'b0);
    check_flag("READY", ready, 1'b0);
    check_data("DATA_OUT_ENABLE pulses", 16'(total_pulses - base), r.size);
  endtask

  // Count every result pulse
  always @(posedge CLK) begin
    if (data_out_enable === 1'b1) begin
      total_pulses <= total_pulses + 1;
    end
  end

  initial begin
    start          = 1'b0;
    data_in_enable = 1'b0;
    size_in        = '0;
    operand_in     = '0;
    build_table();
    @(posedge CLK);
    @(negedge CLK);
    while (RST === 1'b1) begin
      check_reset_outputs();
      @(negedge CLK);
    end
    repeat (4) begin
      check_reset_outputs();
      @(negedge CLK);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("test passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("timeout: the DUT gave no result within %0d cycles", limit_cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: ntm_sinh_tb_clock.sv
//////////////////////////////
// Testbench clock and reset
// Period 4, RST high for 16 cycles
//////////////////////////////

module ntm_sinh_tb_clock (
  output logic CLK,
  output logic RST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    RST = 1'b1;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

// File: ntm_vector_sinh_function.sv
//////////////////////////////
// Vector sinh controller
// Feeds elements one at a time to the scalar engine
// Pulses READY with the last result
//////////////////////////////

module ntm_vector_sinh_function import ntm_sinh_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  sinh_operand_t        OPERAND_IN,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  typedef enum logic [1:0] {
    STARTER_STATE,
    INPUT_STATE,
    ENDER_STATE
  } ctrl_state_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // FSM and element counter
  ctrl_state_t          state;
  logic [DATA_SIZE-1:0] index_loop;

  // Scalar engine
  logic                 start_scalar;
  logic                 ready_scalar;
  sinh_operand_t        operand_scalar;
  logic [DATA_SIZE-1:0] data_out_scalar;

  // Engine READY is stale while its START is still in flight
  logic result_valid;
  assign result_valid = ready_scalar && !start_scalar;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER_STATE;
      index_loop      <= '0;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Single-cycle pulses
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        STARTER_STATE: begin
          if (START) begin
            index_loop <= '0;
            state      <= INPUT_STATE;
          end
        end
        INPUT_STATE: begin
          // Wait here for the next strobe
          if (DATA_IN_ENABLE) begin
            start_scalar <= 1'b1;
            state        <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (result_valid) begin
            DATA_OUT        <= data_out_scalar;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == SIZE_IN - 1'b1) begin
              // Last element of the vector
              READY <= 1'b1;
              state <= STARTER_STATE;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= INPUT_STATE;
            end
          end
        end
        default: state <= STARTER_STATE;
      endcase
    end
  end

  // Operand capture on an accepted strobe
  always_ff @(posedge CLK) begin
    if (state == INPUT_STATE && DATA_IN_ENABLE) begin
      operand_scalar <= OPERAND_IN;
    end
  end

  // Series engine
  ntm_scalar_sinh_function scalar_sinh_function (
    .CLK        (CLK),
    .RST        (RST),
    .START      (start_scalar),
    .OPERAND_IN (operand_scalar),
    .READY      (ready_scalar),
    .DATA_OUT   (data_out_scalar)
  );

  a_size_nonzero: assert property (@(posedge CLK) disable iff (RST)
    START |-> (SIZE_IN != '0))
    else $error("vector started with zero size");

endmodule

// File: ntm_scalar_sinh_function.sv
//////////////////////////////
// Scalar sinh engine
// Taylor series x + x^3/3! + x^5/5! + x^7/7! mod m
// Terms stepped through multiplier and divider
//////////////////////////////

module ntm_scalar_sinh_function import ntm_sinh_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  sinh_operand_t        OPERAND_IN,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  typedef enum logic [2:0] {
    IDLE_STATE,
    REDUCE_STATE,
    MUL_X_STATE,
    MUL_XX_STATE,
    DIVIDE_STATE
  } sinh_state_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Control
  sinh_state_t           state;
  logic [COUNT_SIZE-1:0] reduce_count;
  logic                  reduce_last;
  logic [TERM_SIZE-1:0]  term_index;

  // Payload
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] data_shift;
  logic [DATA_SIZE-1:0] x_value;
  logic [DATA_SIZE-1:0] term;
  logic [DATA_SIZE-1:0] sum;

  // Input reduction step
  logic [DATA_SIZE:0]   reduce_shift;
  logic [DATA_SIZE:0]   reduce_diff;
  logic [DATA_SIZE-1:0] reduce_next;

  // Modular accumulation
  logic [DATA_SIZE:0]   sum_add;
  logic [DATA_SIZE:0]   sum_diff;
  logic [DATA_SIZE-1:0] sum_next;

  // Multiplier
  logic                 mul_start;
  logic                 mul_done;
  logic [DATA_SIZE-1:0] mul_product;

  // Divider
  logic                 div_start;
  logic                 div_done;
  logic [DATA_SIZE-1:0] div_quotient;

  assign reduce_last = (reduce_count == COUNT_SIZE'(DATA_SIZE - 1));

  always_comb begin
    // x mod m, one data bit per cycle from the top
    reduce_shift = {x_value, data_shift[DATA_SIZE-1]};
    reduce_diff  = reduce_shift - {1'b0, modulo};
    reduce_next  = (reduce_shift >= {1'b0, modulo}) ? reduce_diff[DATA_SIZE-1:0]
                                                    : reduce_shift[DATA_SIZE-1:0];
    // sum + term, both below m
    sum_add  = {1'b0, sum} + {1'b0, div_quotient};
    sum_diff = sum_add - {1'b0, modulo};
    sum_next = (sum_add >= {1'b0, modulo}) ? sum_diff[DATA_SIZE-1:0] : sum_add[DATA_SIZE-1:0];
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE_STATE;
      reduce_count <= '0;
      term_index   <= TERM_SIZE'(1);
      mul_start    <= 1'b0;
      div_start    <= 1'b0;
      READY        <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      if (START) begin
        READY        <= 1'b0;
        reduce_count <= '0;
        state        <= REDUCE_STATE;
      end else begin
        case (state)
          REDUCE_STATE: begin
            reduce_count <= reduce_count + 1'b1;
            if (reduce_last) begin
              // First term is x itself
              term_index <= TERM_SIZE'(1);
              mul_start  <= 1'b1;
              state      <= MUL_X_STATE;
            end
          end
          MUL_X_STATE: begin
            if (mul_done) begin
              mul_start <= 1'b1;
              state     <= MUL_XX_STATE;
            end
          end
          MUL_XX_STATE: begin
            if (mul_done) begin
              div_start <= 1'b1;
              state     <= DIVIDE_STATE;
            end
          end
          DIVIDE_STATE: begin
            if (div_done) begin
              if (term_index == TERM_SIZE'(NUM_TERMS - 1)) begin
                // Last term added, hold result
                READY <= 1'b1;
                state <= IDLE_STATE;
              end else begin
                term_index <= term_index + 1'b1;
                mul_start  <= 1'b1;
                state      <= MUL_X_STATE;
              end
            end
          end
          default: state <= IDLE_STATE;
        endcase
      end
    end
  end

  // Datapath registers
  always_ff @(posedge CLK) begin
    if (START) begin
      modulo     <= OPERAND_IN.modulo;
      data_shift <= OPERAND_IN.data;
      x_value    <= '0;
    end else begin
      case (state)
        REDUCE_STATE: begin
          x_value    <= reduce_next;
          data_shift <= data_shift << 1;
          if (reduce_last) begin
            term <= reduce_next;
            sum  <= reduce_next;
          end
        end
        MUL_X_STATE, MUL_XX_STATE: begin
          if (mul_done) begin
            term <= mul_product;
          end
        end
        DIVIDE_STATE: begin
          if (div_done) begin
            term <= div_quotient;
            sum  <= sum_next;
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign DATA_OUT = sum;

  //////////////////////////////
  // Arithmetic units
  //////////////////////////////

  // term * x, twice per term
  ntm_scalar_modular_multiplier modular_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .START     (mul_start),
    .FACTOR_A  (term),
    .FACTOR_B  (x_value),
    .MODULO_IN (modulo),
    .DONE      (mul_done),
    .PRODUCT   (mul_product)
  );

  // term / (2k)(2k+1)
  ntm_scalar_integer_divider integer_divider (
    .CLK      (CLK),
    .RST      (RST),
    .START    (div_start),
    .DIVIDEND (term),
    .DIVISOR  (SINH_DENOM[term_index]),
    .DONE     (div_done),
    .QUOTIENT (div_quotient)
  );

  a_modulo_nonzero: assert property (@(posedge CLK) disable iff (RST)
    START |-> (OPERAND_IN.modulo != '0))
    else $error("sinh engine started with zero modulus");

endmodule

// File: ntm_scalar_integer_divider.sv
//////////////////////////////
// Integer divider
// Restoring shift-subtract, one quotient bit per cycle
//////////////////////////////

module ntm_scalar_integer_divider import ntm_sinh_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] DIVIDEND,
  input  logic [DATA_SIZE-1:0] DIVISOR,
  output logic                 DONE,
  output logic [DATA_SIZE-1:0] QUOTIENT
);

  // Control
  logic                  busy;
  logic                  stepping;
  logic [COUNT_SIZE-1:0] count;

  // Partial remainder, quotient shifts in as dividend shifts out
  logic [DATA_SIZE-1:0] remainder;
  logic [DATA_SIZE-1:0] quotient;
  logic [DATA_SIZE-1:0] divisor;

  // Trial subtraction
  logic [DATA_SIZE:0]   rem_shift;
  logic [DATA_SIZE:0]   rem_diff;
  logic                 fits;
  logic [DATA_SIZE-1:0] rem_next;

  assign stepping = busy && (count != COUNT_SIZE'(DATA_SIZE));

  always_comb begin
    // Bring down next dividend bit
    rem_shift = {remainder, quotient[DATA_SIZE-1]};
    rem_diff  = rem_shift - {1'b0, divisor};
    fits      = (rem_shift >= {1'b0, divisor});
    // Restore on a failed subtraction
    rem_next  = fits ? rem_diff[DATA_SIZE-1:0] : rem_shift[DATA_SIZE-1:0];
  end

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      DONE  <= 1'b0;
    end else begin
      DONE <= 1'b0;
      if (START) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (stepping) begin
        count <= count + 1'b1;
      end else if (busy) begin
        busy <= 1'b0;
        DONE <= 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (START) begin
      remainder <= '0;
      quotient  <= DIVIDEND;
      divisor   <= DIVISOR;
    end else if (stepping) begin
      remainder <= rem_next;
      quotient  <= {quotient[DATA_SIZE-2:0], fits};
    end
  end

  assign QUOTIENT = quotient;

  // Caller never divides by zero
  a_divisor_nonzero: assert property (@(posedge CLK) disable iff (RST)
    START |-> (DIVISOR != '0))
    else $error("divider started with zero divisor");

endmodule

// File: ntm_scalar_modular_multiplier.sv
//////////////////////////////
// Modular multiplier
// Bit-serial shift-add, returns (a*b) mod m
//////////////////////////////

module ntm_scalar_modular_multiplier import ntm_sinh_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] FACTOR_A,
  input  logic [DATA_SIZE-1:0] FACTOR_B,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  output logic                 DONE,
  output logic [DATA_SIZE-1:0] PRODUCT
);

  // Control
  logic                  busy;
  logic                  stepping;
  logic [COUNT_SIZE-1:0] count;

  // Operands and accumulator
  logic [DATA_SIZE-1:0] factor_a;
  logic [DATA_SIZE-1:0] scan_b;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] acc;

  // One step of the scan
  logic [DATA_SIZE:0]   dbl_sum;
  logic [DATA_SIZE:0]   dbl_diff;
  logic [DATA_SIZE-1:0] dbl_red;
  logic [DATA_SIZE:0]   add_sum;
  logic [DATA_SIZE:0]   add_diff;
  logic [DATA_SIZE-1:0] acc_next;

  // Still scanning bits of b
  assign stepping = busy && (count != COUNT_SIZE'(DATA_SIZE));

  always_comb begin
    // Double, then fold back below m
    dbl_sum  = {acc, 1'b0};
    dbl_diff = dbl_sum - {1'b0, modulo};
    dbl_red  = (dbl_sum >= {1'b0, modulo}) ? dbl_diff[DATA_SIZE-1:0] : dbl_sum[DATA_SIZE-1:0];
    // Add a on a set bit, fold again
    add_sum  = {1'b0, dbl_red} + (scan_b[DATA_SIZE-1] ? {1'b0, factor_a} : '0);
    add_diff = add_sum - {1'b0, modulo};
    acc_next = (add_sum >= {1'b0, modulo}) ? add_diff[DATA_SIZE-1:0] : add_sum[DATA_SIZE-1:0];
  end

  //////////////////////////////
  // Sequencing
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      DONE  <= 1'b0;
    end else begin
      DONE <= 1'b0;
      if (START) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (stepping) begin
        count <= count + 1'b1;
      end else if (busy) begin
        // All bits consumed
        busy <= 1'b0;
        DONE <= 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (START) begin
      factor_a <= FACTOR_A;
      scan_b   <= FACTOR_B;
      modulo   <= MODULO_IN;
      acc      <= '0;
    end else if (stepping) begin
      acc    <= acc_next;
      scan_b <= scan_b << 1;
    end
  end

  // Accumulator is stable from DONE until the next START
  assign PRODUCT = acc;

  // Caller keeps both factors reduced
  a_factors_reduced: assert property (@(posedge CLK) disable iff (RST)
    START |-> (FACTOR_A < MODULO_IN) && (FACTOR_B < MODULO_IN))
    else $error("multiplier factor not below modulus");

endmodule

// File: ntm_sinh_pkg.sv
//////////////////////////////
// Sinh vector subsystem
// Shared widths, series table and operand type
//////////////////////////////

package ntm_sinh_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data word width
  localparam int DATA_SIZE = 16;

  // Bit-serial step counter, holds 0 up to DATA_SIZE
  localparam int COUNT_SIZE = $clog2(DATA_SIZE + 1);

  //////////////////////////////
  // Series
  //////////////////////////////

  // Terms of x + x^3/3! + x^5/5! + x^7/7!
  localparam int NUM_TERMS = 4;

  // Term index width
  localparam int TERM_SIZE = $clog2(NUM_TERMS);

  // Step divisors (2k)(2k+1) indexed by k
  localparam logic [NUM_TERMS-1:1][DATA_SIZE-1:0] SINH_DENOM = {
    16'd42,
    16'd20,
    16'd6
  };

  //////////////////////////////
  // Types
  //////////////////////////////

  // One element together with its modulus
  typedef struct packed {
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] data;
  } sinh_operand_t;

endpackage
